//--- logic/replay_pkg.sv
// ------------------------------
// Replay engine shared definitions
// Stream widths, tuser field layout and
// the packet memory word
// ------------------------------

package replay_pkg;

  parameter int DATA_WIDTH   = 64;
  parameter int USER_WIDTH   = 16;

  // One-hot destination field with queue q at bit DST_PORT_POS + 2q
  parameter int DST_PORT_POS = 8;

  parameter int MAX_QUEUES   = 4;
  parameter int ADDR_WIDTH   = 8;
  parameter int COUNT_WIDTH  = 8;

  typedef logic [ADDR_WIDTH-1:0]  addr_t;
  typedef logic [1:0]             qid_t;
  typedef logic [COUNT_WIDTH-1:0] count_t;

  // One stored beat
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } mem_word_t;

endpackage

//--- logic/replay_mem_if.sv
// ------------------------------
// Packet memory port bundles
// Write side from the capture writer,
// read side to the replay reader
// ------------------------------

interface mem_wr_if;
  import replay_pkg::*;

  logic                  en;
  addr_t                 addr;
  logic [DATA_WIDTH-1:0] word;
  logic                  last;

  modport writer (
    output en,
    output addr,
    output word,
    output last
  );

  modport memory (
    input en,
    input addr,
    input word,
    input last
  );
endinterface

interface mem_rd_if;
  import replay_pkg::*;

  logic      rd_en;
  addr_t     rd_addr;
  mem_word_t rd_word;
  // Follows rd_en by exactly one cycle
  logic      rd_valid;

  modport reader (output rd_en, output rd_addr, input rd_word, input rd_valid);
  modport memory (input rd_en, input rd_addr, output rd_word, output rd_valid);
endinterface

//--- logic/capture_writer.sv
// ------------------------------
// Capture writer
// Sorts inbound packets by destination
// queue into per-queue memory windows
// ------------------------------

module capture_writer #(
  parameter int NUM_QUEUES = 4
) (
  input  logic                              axi_aclk,
  input  logic                              rst_n,
  input  logic                              sw_rst,
  input  logic [replay_pkg::DATA_WIDTH-1:0] s_tdata,
  input  logic [replay_pkg::USER_WIDTH-1:0] s_tuser,
  input  logic                              s_tvalid,
  input  logic                              s_tlast,
  output logic                              s_tready,
  input  logic [NUM_QUEUES-1:0]             q_enable,
  input  replay_pkg::addr_t                 addr_low  [NUM_QUEUES],
  input  replay_pkg::addr_t                 addr_high [NUM_QUEUES],
  output replay_pkg::addr_t                 q_end     [NUM_QUEUES],
  mem_wr_if.writer                          wr
);
  import replay_pkg::*;

  logic                  accept;
  logic                  in_pkt;
  qid_t                  cur_q;
  logic                  cur_keep;
  logic                  dst_hit;
  qid_t                  dst_q;
  qid_t                  beat_q;
  logic                  beat_keep;
  logic                  store;
  addr_t                 beat_addr;
  addr_t                 wr_cnt  [NUM_QUEUES];
  addr_t                 end_cnt [NUM_QUEUES];
  logic [NUM_QUEUES-1:0] full;
  qid_t                  wr_q;

  // Capture never stalls outside reset
  assign s_tready = rst_n;
  assign accept   = s_tvalid && s_tready;

  // Lowest queue whose destination bit is set
  always_comb begin
    dst_hit = 1'b0;
    dst_q   = '0;
    for (int q = NUM_QUEUES - 1; q >= 0; q--) begin
      if (s_tuser[DST_PORT_POS + 2*q]) begin
        dst_hit = 1'b1;
        dst_q   = qid_t'(q);
      end
    end
  end

  assign beat_q    = in_pkt ? cur_q : dst_q;
  assign beat_keep = in_pkt ? cur_keep : (dst_hit && q_enable[dst_q]);
  assign store     = accept && beat_keep && !full[beat_q];
  assign beat_addr = addr_low[beat_q] + wr_cnt[beat_q];

  always_ff @(posedge axi_aclk) begin
    if (!rst_n || sw_rst) begin
      in_pkt   <= 1'b0;
      cur_q    <= '0;
      cur_keep <= 1'b0;
      wr.en    <= 1'b0;
      full     <= '0;
      for (int q = 0; q < NUM_QUEUES; q++) begin
        wr_cnt[q]  <= '0;
        end_cnt[q] <= '0;
      end
    end else begin
      wr.en <= store;
      if (accept) begin
        in_pkt <= !s_tlast;
        if (!in_pkt) begin
          cur_q    <= dst_q;
          cur_keep <= dst_hit && q_enable[dst_q];
        end
      end
      if (store) begin
        wr_cnt[beat_q] <= wr_cnt[beat_q] + 1'b1;
        // Queue stays closed until the next reset once its window is used up
        if (beat_addr == addr_high[beat_q]) begin
          full[beat_q] <= 1'b1;
        end
      end
      if (wr.en) begin
        end_cnt[wr_q] <= end_cnt[wr_q] + 1'b1;
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    wr.addr <= beat_addr;
    wr.word <= s_tdata;
    wr.last <= s_tlast || (beat_addr == addr_high[beat_q]);
    wr_q    <= beat_q;
  end

  // End pointer follows the memory write rather than the accept
  always_comb begin
    for (int q = 0; q < NUM_QUEUES; q++) begin
      q_end[q] = addr_low[q] + end_cnt[q];
    end
  end

endmodule

//--- logic/packet_memory.sv
// ------------------------------
// Packet memory
// Dual-port store, one write and one
// registered read per cycle
// ------------------------------

module packet_memory (
  input  logic     axi_aclk,
  mem_wr_if.memory wr,
  mem_rd_if.memory rd
);
  import replay_pkg::*;

  localparam int DEPTH = 2**ADDR_WIDTH;

  mem_word_t mem [DEPTH];

  always_ff @(posedge axi_aclk) begin
    if (wr.en) begin
      mem[wr.addr] <= '{data: wr.word, last: wr.last};
    end
  end

  // Read returns the old word on an address collision
  always_ff @(posedge axi_aclk) begin
    if (rd.rd_en) begin
      rd.rd_word <= mem[rd.rd_addr];
    end
  end

  always_ff @(posedge axi_aclk) begin
    rd.rd_valid <= rd.rd_en;
  end

endmodule

//--- logic/replay_reader.sv
// ------------------------------
// Replay reader
// Schedules queue replays and streams
// memory contents out under back-pressure
// ------------------------------

module replay_reader #(
  parameter int NUM_QUEUES = 4
) (
  input  logic                              axi_aclk,
  input  logic                              rst_n,
  input  logic                              sw_rst,
  input  logic [NUM_QUEUES-1:0]             q_enable,
  input  logic [NUM_QUEUES-1:0]             start_replay,
  input  replay_pkg::count_t                replay_count [NUM_QUEUES],
  input  replay_pkg::addr_t                 addr_low     [NUM_QUEUES],
  input  replay_pkg::addr_t                 q_end        [NUM_QUEUES],
  mem_rd_if.reader                          rd,
  output logic [replay_pkg::DATA_WIDTH-1:0] m_tdata,
  output logic                              m_tlast,
  output replay_pkg::qid_t                  m_qid,
  output logic                              m_tvalid,
  input  logic                              m_tready,
  output logic [NUM_QUEUES-1:0]             replay_busy
);
  import replay_pkg::*;

  logic [NUM_QUEUES-1:0] pend;
  count_t                cfg_count [NUM_QUEUES];
  logic                  pick_hit;
  qid_t                  pick_q;

  logic                  active;
  qid_t                  act_q;
  addr_t                 rd_ptr;
  addr_t                 act_last;
  count_t                reps;
  logic                  at_end;
  logic                  issue;
  logic [2:0]            occ;

  qid_t                  req_qid;
  logic                  req_fin;
  qid_t                  rsp_qid;
  logic                  rsp_fin;
  logic                  flush;
  logic                  push;
  logic                  pop;

  logic [DATA_WIDTH-1:0] buf_data [2];
  logic                  buf_last [2];
  qid_t                  buf_qid  [2];
  logic                  buf_fin  [2];
  logic                  buf_wr;
  logic                  buf_rd;
  logic [1:0]            buf_cnt;

  // Lowest pending queue goes next
  always_comb begin
    pick_hit = 1'b0;
    pick_q   = '0;
    for (int q = NUM_QUEUES - 1; q >= 0; q--) begin
      if (pend[q]) begin
        pick_hit = 1'b1;
        pick_q   = qid_t'(q);
      end
    end
  end

  assign push   = rd.rd_valid && !flush;
  assign pop    = m_tvalid && m_tready;
  assign at_end = (rd_ptr == act_last);

  // Reads in flight plus buffered beats never exceed two
  assign occ   = {1'b0, buf_cnt} + rd.rd_en + push;
  assign issue = active && (occ < (pop ? 3'd3 : 3'd2));

  always_ff @(posedge axi_aclk) begin
    if (!rst_n || sw_rst) begin
      replay_busy <= '0;
      pend        <= '0;
      active      <= 1'b0;
      rd.rd_en    <= 1'b0;
      flush       <= 1'b1;
      buf_wr      <= 1'b0;
      buf_rd      <= 1'b0;
      buf_cnt     <= '0;
    end else begin
      flush    <= 1'b0;
      rd.rd_en <= issue;
      for (int q = 0; q < NUM_QUEUES; q++) begin
        if (start_replay[q] && q_enable[q] && !replay_busy[q]) begin
          replay_busy[q] <= 1'b1;
          pend[q]        <= 1'b1;
          cfg_count[q]   <= replay_count[q];
        end
      end
      if (!active && pick_hit) begin
        pend[pick_q] <= 1'b0;
        // Nothing to send for a zero count or empty window
        if (cfg_count[pick_q] == '0 || q_end[pick_q] == addr_low[pick_q]) begin
          replay_busy[pick_q] <= 1'b0;
        end else begin
          active   <= 1'b1;
          act_q    <= pick_q;
          rd_ptr   <= addr_low[pick_q];
          act_last <= q_end[pick_q] - 1'b1;
          reps     <= cfg_count[pick_q];
        end
      end
      if (issue) begin
        if (!at_end) begin
          rd_ptr <= rd_ptr + 1'b1;
        end else if (reps == count_t'(1)) begin
          active <= 1'b0;
        end else begin
          reps   <= reps - 1'b1;
          rd_ptr <= addr_low[act_q];
        end
      end
      if (push) begin
        buf_wr <= !buf_wr;
      end
      if (pop) begin
        buf_rd <= !buf_rd;
        if (buf_fin[buf_rd]) begin
          replay_busy[buf_qid[buf_rd]] <= 1'b0;
        end
      end
      buf_cnt <= buf_cnt + 2'(push) - 2'(pop);
    end
  end

  // Side-band travels alongside the memory read
  always_ff @(posedge axi_aclk) begin
    rd.rd_addr <= rd_ptr;
    req_qid    <= act_q;
    req_fin    <= at_end && (reps == count_t'(1));
    rsp_qid    <= req_qid;
    rsp_fin    <= req_fin;
    if (push) begin
      buf_data[buf_wr] <= rd.rd_word.data;
      buf_last[buf_wr] <= rd.rd_word.last;
      buf_qid[buf_wr]  <= rsp_qid;
      buf_fin[buf_wr]  <= rsp_fin;
    end
  end

  assign m_tvalid = (buf_cnt != 2'd0);
  assign m_tdata  = buf_data[buf_rd];
  assign m_tlast  = buf_last[buf_rd];
  assign m_qid    = buf_qid[buf_rd];

endmodule

//--- logic/pcap_replay_top.sv
// ------------------------------
// Packet capture and replay engine
// Capture writer, packet memory and
// replay reader on one clock
// ------------------------------

module pcap_replay_top #(
  parameter int NUM_QUEUES = 4
) (
  input  logic                              axi_aclk,
  input  logic                              rst_n,
  input  logic                              sw_rst,

  input  logic [replay_pkg::DATA_WIDTH-1:0] s_tdata,
  input  logic [replay_pkg::USER_WIDTH-1:0] s_tuser,
  input  logic                              s_tvalid,
  input  logic                              s_tlast,
  output logic                              s_tready,

  output logic [replay_pkg::DATA_WIDTH-1:0] m_tdata,
  output logic                              m_tlast,
  output replay_pkg::qid_t                  m_qid,
  output logic                              m_tvalid,
  input  logic                              m_tready,

  input  logic [NUM_QUEUES-1:0]             q_enable,
  input  replay_pkg::addr_t                 addr_low     [NUM_QUEUES],
  input  replay_pkg::addr_t                 addr_high    [NUM_QUEUES],
  input  replay_pkg::count_t                replay_count [NUM_QUEUES],
  input  logic [NUM_QUEUES-1:0]             start_replay,
  output logic [NUM_QUEUES-1:0]             replay_busy
);
  import replay_pkg::*;

  addr_t q_end [NUM_QUEUES];

  mem_wr_if wr_bus ();
  mem_rd_if rd_bus ();

  capture_writer #(
    .NUM_QUEUES (NUM_QUEUES)
  ) capture_writer_i (
    .axi_aclk  (axi_aclk),
    .rst_n     (rst_n),
    .sw_rst    (sw_rst),
    .s_tdata   (s_tdata),
    .s_tuser   (s_tuser),
    .s_tvalid  (s_tvalid),
    .s_tlast   (s_tlast),
    .s_tready  (s_tready),
    .q_enable  (q_enable),
    .addr_low  (addr_low),
    .addr_high (addr_high),
    .q_end     (q_end),
    .wr        (wr_bus.writer)
  );

  packet_memory packet_memory_i (
    .axi_aclk (axi_aclk),
    .wr       (wr_bus.memory),
    .rd       (rd_bus.memory)
  );

  replay_reader #(
    .NUM_QUEUES (NUM_QUEUES)
  ) replay_reader_i (
    .axi_aclk     (axi_aclk),
    .rst_n        (rst_n),
    .sw_rst       (sw_rst),
    .q_enable     (q_enable),
    .start_replay (start_replay),
    .replay_count (replay_count),
    .addr_low     (addr_low),
    .q_end        (q_end),
    .rd           (rd_bus.reader),
    .m_tdata      (m_tdata),
    .m_tlast      (m_tlast),
    .m_qid        (m_qid),
    .m_tvalid     (m_tvalid),
    .m_tready     (m_tready),
    .replay_busy  (replay_busy)
  );

endmodule

//--- dv/pcap_replay_assertions.sv
// ------------------------------
// Replay engine protocol checks
// Output stream stability and
// reset values at the top level
// ------------------------------

module pcap_replay_assertions #(
  parameter int NUM_QUEUES = 4
) (
  input logic                              axi_aclk,
  input logic                              rst_n,
  input logic                              sw_rst,
  input logic                              s_tready,
  input logic [replay_pkg::DATA_WIDTH-1:0] m_tdata,
  input logic                              m_tlast,
  input replay_pkg::qid_t                  m_qid,
  input logic                              m_tvalid,
  input logic                              m_tready,
  input logic [NUM_QUEUES-1:0]             replay_busy
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // A stalled beat holds until it transfers
  hold_while_stalled: assert property (@(posedge axi_aclk) disable iff (!rst_n || sw_rst)
    (m_tvalid && !m_tready) |=>
      (m_tvalid && $stable(m_tdata) && $stable(m_tlast) && $stable(m_qid)))
    else begin
      $error("m_ stream changed while stalled");
      fail_count++;
    end

  idle_in_reset: assert property (@(posedge axi_aclk)
    !rst_n |=> (!m_tvalid && replay_busy == '0))
    else begin
      $error("m_tvalid or replay_busy high after a reset cycle");
      fail_count++;
    end

  ready_out_of_reset: assert property (@(posedge axi_aclk) rst_n |-> s_tready)
    else begin
      $error("s_tready low outside reset");
      fail_count++;
    end

endmodule

bind pcap_replay_top pcap_replay_assertions #(
  .NUM_QUEUES (NUM_QUEUES)
) assertions_i (
  .axi_aclk    (axi_aclk),
  .rst_n       (rst_n),
  .sw_rst      (sw_rst),
  .s_tready    (s_tready),
  .m_tdata     (m_tdata),
  .m_tlast     (m_tlast),
  .m_qid       (m_qid),
  .m_tvalid    (m_tvalid),
  .m_tready    (m_tready),
  .replay_busy (replay_busy)
);

//--- dv/pcap_replay_tb.sv
// ------------------------------
// Replay engine testbench
// Random capture traffic, replay model
// and output stream checks
// ------------------------------

module pcap_replay_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import replay_pkg::*;

  localparam int NUM_QUEUES     = 4;
  localparam int TIMEOUT_CYCLES = 5000;

  logic                  axi_aclk;
  logic                  rst_n;
  logic                  sw_rst;
  logic [DATA_WIDTH-1:0] s_tdata;
  logic [USER_WIDTH-1:0] s_tuser;
  logic                  s_tvalid;
  logic                  s_tlast;
  logic                  s_tready;
  logic [DATA_WIDTH-1:0] m_tdata;
  logic                  m_tlast;
  qid_t                  m_qid;
  logic                  m_tvalid;
  logic                  m_tready;
  logic [NUM_QUEUES-1:0] q_enable;
  addr_t                 addr_low     [NUM_QUEUES];
  addr_t                 addr_high    [NUM_QUEUES];
  count_t                replay_count [NUM_QUEUES];
  logic [NUM_QUEUES-1:0] start_replay;
  logic [NUM_QUEUES-1:0] replay_busy;

  logic [31:0]           lcg_state = 32'hf987_63dd;
  logic                  ready_random;

  // Captured beats per queue as {last, data}
  logic [DATA_WIDTH:0]   stored [NUM_QUEUES][256];
  int                    stored_len [NUM_QUEUES];
  logic [NUM_QUEUES-1:0] model_full;
  logic                  model_in_pkt;
  logic                  model_keep;
  qid_t                  model_q;
  // Expected output beats as {qid, last, data}
  logic [DATA_WIDTH+2:0] exp_q [$];
  logic [DATA_WIDTH+2:0] exp_beat;

  pcap_replay_top #(
    .NUM_QUEUES (NUM_QUEUES)
  ) pcap_replay_top_i (
    .axi_aclk     (axi_aclk),
    .rst_n        (rst_n),
    .sw_rst       (sw_rst),
    .s_tdata      (s_tdata),
    .s_tuser      (s_tuser),
    .s_tvalid     (s_tvalid),
    .s_tlast      (s_tlast),
    .s_tready     (s_tready),
    .m_tdata      (m_tdata),
    .m_tlast      (m_tlast),
    .m_qid        (m_qid),
    .m_tvalid     (m_tvalid),
    .m_tready     (m_tready),
    .q_enable     (q_enable),
    .addr_low     (addr_low),
    .addr_high    (addr_high),
    .replay_count (replay_count),
    .start_replay (start_replay),
    .replay_busy  (replay_busy)
  );

  always #5 axi_aclk = ~axi_aclk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = next_rand();
    return lo + int'((r >> 8) % (hi - lo + 1));
  endfunction

  function automatic logic [USER_WIDTH-1:0] dst_bit(input int q);
    return USER_WIDTH'(1) << (DST_PORT_POS + 2 * q);
  endfunction

  // Random tuser with every destination bit cleared
  function automatic logic [USER_WIDTH-1:0] user_noise();
    logic [31:0]           r;
    logic [USER_WIDTH-1:0] u;
    r = next_rand();
    u = r[USER_WIDTH-1:0];
    for (int q = 0; q < NUM_QUEUES; q++) begin
      u = u & ~dst_bit(q);
    end
    return u;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("error %0t: %s is %0h, expected %0h", $time, what, got, exp));
    end
  endtask

  task automatic tick();
    logic [31:0] r;
    @(posedge axi_aclk);
    #1;
    r = next_rand();
    m_tready = ready_random ? r[20] : 1'b1;
  endtask

  // Capture rules applied to one accepted beat
  function automatic void model_beat(input logic [DATA_WIDTH-1:0] data,
                                     input logic [USER_WIDTH-1:0] user, input logic last);
    addr_t addr;
    logic  found;
    if (!model_in_pkt) begin
      found = 1'b0;
      for (int q = 0; q < NUM_QUEUES; q++) begin
        if (!found && user[DST_PORT_POS + 2 * q]) begin
          found   = 1'b1;
          model_q = qid_t'(q);
        end
      end
      model_keep = found && q_enable[model_q];
    end
    if (model_keep && !model_full[model_q]) begin
      addr = addr_low[model_q] + addr_t'(stored_len[model_q]);
      stored[model_q][stored_len[model_q]] = {last || (addr == addr_high[model_q]), data};
      stored_len[model_q]++;
      if (addr == addr_high[model_q]) begin
        model_full[model_q] = 1'b1;
      end
    end
    model_in_pkt = !last;
  endfunction

  task automatic send_packet(input logic [USER_WIDTH-1:0] user, input int len);
    logic [31:0] hi;
    logic [31:0] lo;
    for (int i = 0; i < len; i++) begin
      hi       = next_rand();
      lo       = next_rand();
      s_tdata  = {hi, lo};
      s_tuser  = user;
      s_tvalid = 1'b1;
      s_tlast  = (i == len - 1);
      model_beat(s_tdata, user, s_tlast);
      tick();
    end
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
  endtask

  // Accepted starts replay in ascending queue order
  task automatic start_queues(input logic [NUM_QUEUES-1:0] mask);
    for (int q = 0; q < NUM_QUEUES; q++) begin
      if (mask[q] && q_enable[q]) begin
        for (int r = 0; r < int'(replay_count[q]); r++) begin
          for (int i = 0; i < stored_len[q]; i++) begin
            exp_q.push_back({qid_t'(q), stored[q][i]});
          end
        end
      end
    end
    start_replay = mask;
    tick();
    start_replay = '0;
  endtask

  task automatic wait_idle(input string what);
    int cycles;
    cycles = 0;
    while (replay_busy != '0) begin
      if (cycles == TIMEOUT_CYCLES) begin
        stop_run($sformatf("timeout: replay_busy never fell during %s", what));
      end
      tick();
      cycles++;
    end
    check_value({what, ": beats not replayed"}, 64'(exp_q.size()), 64'd0);
  endtask

  always @(posedge axi_aclk) begin
    if (rst_n && m_tvalid && m_tready) begin
      if (exp_q.size() == 0) begin
        stop_run($sformatf("unexpected output beat for queue %0d at %0t", m_qid, $time));
      end else begin
        exp_beat = exp_q.pop_front();
        check_value("m_qid", 64'(m_qid), 64'(exp_beat[DATA_WIDTH+2:DATA_WIDTH+1]));
        check_value("m_tlast", 64'(m_tlast), 64'(exp_beat[DATA_WIDTH]));
        check_value("m_tdata", m_tdata, exp_beat[DATA_WIDTH-1:0]);
      end
    end
  end

  initial begin
    axi_aclk     = 1'b0;
    rst_n        = 1'b0;
    sw_rst       = 1'b0;
    s_tdata      = '0;
    s_tuser      = '0;
    s_tvalid     = 1'b0;
    s_tlast      = 1'b0;
    m_tready     = 1'b0;
    q_enable     = '0;
    start_replay = '0;
    ready_random = 1'b0;
    model_full   = '0;
    model_in_pkt = 1'b0;
    model_keep   = 1'b0;
    model_q      = '0;
    // Queue 1 gets a small window for the overflow case
    for (int q = 0; q < NUM_QUEUES; q++) begin
      addr_low[q]     = addr_t'(q * 64 + rand_range(0, 7));
      addr_high[q]    = addr_low[q] + addr_t'(q == 1 ? rand_range(3, 6) : rand_range(20, 50));
      replay_count[q] = '0;
      stored_len[q]   = 0;
    end
    repeat (5) @(posedge axi_aclk);
    #1;
    rst_n    = 1'b1;
    m_tready = 1'b1;
    q_enable = '1;
    tick();

    // Single replay on queue 0
    for (int p = 0; p < 3; p++) begin
      send_packet(dst_bit(0) | user_noise(), rand_range(1, 6));
    end
    tick();
    replay_count[0] = 1;
    start_queues(4'b0001);
    wait_idle("single replay");

    // Repeat count and then a zero count
    replay_count[0] = count_t'(rand_range(2, 5));
    start_queues(4'b0001);
    wait_idle("repeated replay");
    replay_count[0] = 0;
    start_queues(4'b0001);
    wait_idle("zero count replay");

    // Overflow of the queue 1 window
    for (int p = 0; p < 5; p++) begin
      send_packet(dst_bit(1) | user_noise(), rand_range(2, 4));
    end
    tick();
    replay_count[1] = 1;
    start_queues(4'b0010);
    wait_idle("window overflow replay");

    // Filtering with queue 2 disabled
    q_enable = 4'b1011;
    send_packet(user_noise(), 3);
    send_packet(dst_bit(2) | user_noise(), 2);
    send_packet(dst_bit(2) | dst_bit(3) | user_noise(), 2);
    send_packet(dst_bit(3) | user_noise(), 3);
    tick();
    replay_count[2] = 1;
    start_queues(4'b0100);
    check_value("replay_busy[2] after start on disabled queue", 64'(replay_busy[2]), 64'd0);
    replay_count[3] = 1;
    start_queues(4'b1000);
    wait_idle("filtered replay");
    q_enable = '1;

    // All queues at once under random back-pressure
    for (int p = 0; p < 12; p++) begin
      send_packet(USER_WIDTH'(next_rand()), rand_range(1, 5));
    end
    tick();
    for (int q = 0; q < NUM_QUEUES; q++) begin
      replay_count[q] = count_t'(rand_range(1, 3));
    end
    ready_random = 1'b1;
    start_queues('1);
    wait_idle("multi-queue replay");
    ready_random = 1'b0;

    // Software reset drops everything captured so far
    sw_rst = 1'b1;
    tick();
    sw_rst       = 1'b0;
    model_full   = '0;
    model_in_pkt = 1'b0;
    for (int q = 0; q < NUM_QUEUES; q++) begin
      stored_len[q] = 0;
    end
    tick();
    replay_count[0] = 2;
    start_queues(4'b0001);
    wait_idle("replay after software reset");
    send_packet(dst_bit(0) | user_noise(), rand_range(1, 4));
    send_packet(dst_bit(3) | user_noise(), rand_range(1, 4));
    tick();
    replay_count[3] = 2;
    start_queues(4'b1001);
    wait_idle("capture after software reset");

    if (pcap_replay_top_i.assertions_i.fail_count != 0) begin
      stop_run("a protocol assertion on the top level failed during the run");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

//--- list.f
logic/replay_pkg.sv
logic/replay_mem_if.sv
logic/capture_writer.sv
logic/packet_memory.sv
logic/replay_reader.sv
logic/pcap_replay_top.sv
dv/pcap_replay_assertions.sv
dv/pcap_replay_tb.sv
